/* hw/ccu_vq_config.svh */
// Build-time sizes of the victim queue
// Included by the package and by every module that sizes a port from these values

`ifndef CCU_VQ_CONFIG_SVH
`define CCU_VQ_CONFIG_SVH

// Number of queue entries
`define CCU_VQ_DEPTH 4
// Line address with the byte offset stripped
`define CCU_VQ_ADDR_WIDTH 26
// Cache line data width
`define CCU_VQ_LINE_WIDTH 64

`endif

/* hw/ccu_vq_pkg.sv */
// Shared types of the victim queue
// Import into any module that needs the entry state or an entry index

`default_nettype none

`include "ccu_vq_config.svh"

package ccu_vq_pkg;

    // Occupancy of a single queue entry
    typedef enum logic [0:0] {
        VQ_ENTRY_INVALID = 1'b0,
        VQ_ENTRY_VALID   = 1'b1
    } vq_entry_state_t;

    // Index into the queue
    typedef logic [$clog2(`CCU_VQ_DEPTH)-1:0] vq_idx_t;

endpackage

`default_nettype wire

/* hw/ccu_vq_entry.sv */
// One victim queue entry with its line address, line data and lookup compare
// Instantiated once per queue slot by the top level

`timescale 1ns/1ps
`default_nettype none

`include "ccu_vq_config.svh"

module ccu_vq_entry
    import ccu_vq_pkg::*;
(
    input  logic                          clk,
    input  logic                          i_rst,

    // Allocation into this slot
    input  logic                          i_alloc_en,
    input  logic [`CCU_VQ_ADDR_WIDTH-1:0] i_alloc_addr,
    input  logic [`CCU_VQ_LINE_WIDTH-1:0] i_alloc_data,

    // Lookup address from the load/store path
    input  logic [`CCU_VQ_ADDR_WIDTH-1:0] i_lookup_addr,

    // Write-back of this slot has finished
    input  logic                          i_done,

    output logic                          o_valid,
    output logic [`CCU_VQ_ADDR_WIDTH-1:0] o_addr,
    output logic [`CCU_VQ_LINE_WIDTH-1:0] o_data,
    output logic                          o_lookup_hit
);

    vq_entry_state_t state_r;
    vq_entry_state_t state_next;
    logic [`CCU_VQ_ADDR_WIDTH-1:0] addr_r;
    logic [`CCU_VQ_LINE_WIDTH-1:0] data_r;

    // Invalid -> valid on allocate, valid -> invalid on done
    always_comb begin
        state_next = state_r;
        case (state_r)
            VQ_ENTRY_INVALID: if (i_alloc_en) state_next = VQ_ENTRY_VALID;
            VQ_ENTRY_VALID:   if (i_done) state_next = VQ_ENTRY_INVALID;
            default:          state_next = VQ_ENTRY_INVALID;
        endcase
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            state_r <= VQ_ENTRY_INVALID;
        end else begin
            state_r <= state_next;
        end
    end

    // Payload only moves on allocation
    always_ff @(posedge clk) begin
        if (i_alloc_en) begin
            addr_r <= i_alloc_addr;
            data_r <= i_alloc_data;
        end
    end

    assign o_valid      = (state_r == VQ_ENTRY_VALID);
    assign o_addr       = addr_r;
    assign o_data       = data_r;
    assign o_lookup_hit = o_valid & (addr_r == i_lookup_addr);

endmodule

`default_nettype wire

/* hw/ccu_vq_alloc.sv */
// Free-slot allocator for the victim queue
// Picks the lowest invalid entry for an incoming victim and flags a full queue

`timescale 1ns/1ps
`default_nettype none

`include "ccu_vq_config.svh"

module ccu_vq_alloc
    import ccu_vq_pkg::*;
(
    input  logic                     i_vict_en,
    input  logic [`CCU_VQ_DEPTH-1:0] i_entry_valid,

    output logic [`CCU_VQ_DEPTH-1:0] o_alloc_en,
    output logic                     o_full
);

    vq_idx_t free_idx;

    // Lowest free slot wins, so scan from the top down
    always_comb begin
        free_idx = '0;
        for (int i = `CCU_VQ_DEPTH - 1; i >= 0; i--) begin
            if (!i_entry_valid[i]) begin
                free_idx = vq_idx_t'(i);
            end
        end
    end

    assign o_full = &i_entry_valid;

    // Victims arriving while full are dropped here
    always_comb begin
        o_alloc_en = '0;
        if (i_vict_en && !o_full) begin
            o_alloc_en[free_idx] = 1'b1;
        end
    end

endmodule

`default_nettype wire

/* hw/ccu_vq_drain.sv */
// Drain engine writing victim lines back to memory
// Takes the lowest valid entry, holds the request level until memory acknowledges,
// then frees that entry

`timescale 1ns/1ps
`default_nettype none

`include "ccu_vq_config.svh"

module ccu_vq_drain
    import ccu_vq_pkg::*;
(
    input  logic                          clk,
    input  logic                          i_rst,

    // Entry contents
    input  logic [`CCU_VQ_DEPTH-1:0]      i_entry_valid,
    input  logic [`CCU_VQ_ADDR_WIDTH-1:0] i_entry_addr [`CCU_VQ_DEPTH],
    input  logic [`CCU_VQ_LINE_WIDTH-1:0] i_entry_data [`CCU_VQ_DEPTH],

    // Memory write-back
    input  logic                          i_wb_done,
    output logic                          o_wb_req,
    output logic [`CCU_VQ_ADDR_WIDTH-1:0] o_wb_addr,
    output logic [`CCU_VQ_LINE_WIDTH-1:0] o_wb_data,

    // Frees the drained entry
    output logic [`CCU_VQ_DEPTH-1:0]      o_entry_done
);

    logic    busy_r;
    vq_idx_t idx_r;
    vq_idx_t pick_idx;
    logic    any_valid;

    // Lowest valid index is drained first
    always_comb begin
        pick_idx = '0;
        for (int i = `CCU_VQ_DEPTH - 1; i >= 0; i--) begin
            if (i_entry_valid[i]) begin
                pick_idx = vq_idx_t'(i);
            end
        end
    end

    assign any_valid = |i_entry_valid;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            busy_r <= 1'b0;
            idx_r  <= '0;
        end else if (!busy_r) begin
            if (any_valid) begin
                busy_r <= 1'b1;
                idx_r  <= pick_idx;
            end
        end else if (i_wb_done) begin
            // Back to idle and the next pick follows one cycle later
            busy_r <= 1'b0;
        end
    end

    assign o_wb_req = busy_r;

    // The held entry cannot change while it is valid, so these stay stable
    assign o_wb_addr = i_entry_addr[idx_r];
    assign o_wb_data = i_entry_data[idx_r];

    always_comb begin
        o_entry_done = '0;
        if (busy_r && i_wb_done) begin
            o_entry_done[idx_r] = 1'b1;
        end
    end

endmodule

`default_nettype wire

/* hw/ccu_vq_lookup.sv */
// Lookup result merge for the victim queue
// Folds the per-entry hits into one flag and forwards the hitting line

`timescale 1ns/1ps
`default_nettype none

`include "ccu_vq_config.svh"

module ccu_vq_lookup (
    input  logic [`CCU_VQ_DEPTH-1:0]      i_entry_hit,
    input  logic [`CCU_VQ_LINE_WIDTH-1:0] i_entry_data [`CCU_VQ_DEPTH],

    output logic                          o_lookup_hit,
    output logic [`CCU_VQ_LINE_WIDTH-1:0] o_lookup_data
);

    assign o_lookup_hit = |i_entry_hit;

    // At most one entry hits since addresses are unique in the queue,
    // so an AND-OR mux is enough and gives zero on a miss
    always_comb begin
        o_lookup_data = '0;
        for (int i = 0; i < `CCU_VQ_DEPTH; i++) begin
            o_lookup_data = o_lookup_data
                          | ({`CCU_VQ_LINE_WIDTH{i_entry_hit[i]}} & i_entry_data[i]);
        end
    end

endmodule

`default_nettype wire

/* hw/ccu_vq_top.sv */
// Victim queue of the cache coherence unit
// Accepts evicted dirty lines, serves lookups from them and drains them to memory

`timescale 1ns/1ps
`default_nettype none

`include "ccu_vq_config.svh"

module ccu_vq_top (
    input  logic                          clk,
    input  logic                          i_rst,

    // Victim from the data cache
    input  logic                          i_vict_en,
    input  logic [`CCU_VQ_ADDR_WIDTH-1:0] i_vict_addr,
    input  logic [`CCU_VQ_LINE_WIDTH-1:0] i_vict_data,
    output logic                          o_full,

    // Load/store lookup
    input  logic [`CCU_VQ_ADDR_WIDTH-1:0] i_lookup_addr,
    output logic                          o_lookup_hit,
    output logic [`CCU_VQ_LINE_WIDTH-1:0] o_lookup_data,

    // Memory write-back
    output logic                          o_wb_req,
    output logic [`CCU_VQ_ADDR_WIDTH-1:0] o_wb_addr,
    output logic [`CCU_VQ_LINE_WIDTH-1:0] o_wb_data,
    input  logic                          i_wb_done
);

    logic [`CCU_VQ_DEPTH-1:0]      alloc_en;
    logic [`CCU_VQ_DEPTH-1:0]      entry_done;
    logic [`CCU_VQ_DEPTH-1:0]      entry_valid;
    logic [`CCU_VQ_DEPTH-1:0]      entry_hit;
    logic [`CCU_VQ_ADDR_WIDTH-1:0] entry_addr [`CCU_VQ_DEPTH];
    logic [`CCU_VQ_LINE_WIDTH-1:0] entry_data [`CCU_VQ_DEPTH];

    ccu_vq_alloc u_alloc (
        .i_vict_en     (i_vict_en),
        .i_entry_valid (entry_valid),
        .o_alloc_en    (alloc_en),
        .o_full        (o_full)
    );

    // Every slot sees the victim payload, only the strobed one loads it
    genvar gi;
    generate
        for (gi = 0; gi < `CCU_VQ_DEPTH; gi++) begin : g_entry
            ccu_vq_entry u_entry (
                .clk           (clk),
                .i_rst         (i_rst),
                .i_alloc_en    (alloc_en[gi]),
                .i_alloc_addr  (i_vict_addr),
                .i_alloc_data  (i_vict_data),
                .i_lookup_addr (i_lookup_addr),
                .i_done        (entry_done[gi]),
                .o_valid       (entry_valid[gi]),
                .o_addr        (entry_addr[gi]),
                .o_data        (entry_data[gi]),
                .o_lookup_hit  (entry_hit[gi])
            );
        end
    endgenerate

    ccu_vq_lookup u_lookup (
        .i_entry_hit   (entry_hit),
        .i_entry_data  (entry_data),
        .o_lookup_hit  (o_lookup_hit),
        .o_lookup_data (o_lookup_data)
    );

    ccu_vq_drain u_drain (
        .clk           (clk),
        .i_rst         (i_rst),
        .i_entry_valid (entry_valid),
        .i_entry_addr  (entry_addr),
        .i_entry_data  (entry_data),
        .i_wb_done     (i_wb_done),
        .o_wb_req      (o_wb_req),
        .o_wb_addr     (o_wb_addr),
        .o_wb_data     (o_wb_data),
        .o_entry_done  (entry_done)
    );

endmodule

`default_nettype wire

/* sim/ccu_vq_tb.sv */
// Testbench for the victim queue
// Applies a table of victim, lookup and stall steps and checks the DUT against a
// reference model, while a memory responder acknowledges write-backs after random delays

`timescale 1ns/1ps
`default_nettype none

`include "ccu_vq_config.svh"

module ccu_vq_tb
    import ccu_vq_pkg::*;
();

    localparam int OP_VICT      = 0;
    localparam int OP_LOOK      = 1;
    localparam int OP_IDLE      = 2;
    localparam int OP_STALL_ON  = 3;
    localparam int OP_STALL_OFF = 4;
    localparam int OP_DRAIN     = 5;
    localparam int OP_FULL      = 6;

    // One table row where exp_bit is the expected hit, or the expected o_full for OP_FULL
    typedef struct packed {
        int                            op;
        logic [`CCU_VQ_ADDR_WIDTH-1:0] addr;
        logic [`CCU_VQ_LINE_WIDTH-1:0] data;
        bit                            chk;
        bit                            exp_bit;
        logic [`CCU_VQ_LINE_WIDTH-1:0] exp_data;
    } step_t;

    logic                          clk = 1'b0;
    logic                          i_rst;
    logic                          i_vict_en;
    logic [`CCU_VQ_ADDR_WIDTH-1:0] i_vict_addr;
    logic [`CCU_VQ_LINE_WIDTH-1:0] i_vict_data;
    logic                          o_full;
    logic [`CCU_VQ_ADDR_WIDTH-1:0] i_lookup_addr;
    logic                          o_lookup_hit;
    logic [`CCU_VQ_LINE_WIDTH-1:0] o_lookup_data;
    logic                          o_wb_req;
    logic [`CCU_VQ_ADDR_WIDTH-1:0] o_wb_addr;
    logic [`CCU_VQ_LINE_WIDTH-1:0] o_wb_data;
    logic                          i_wb_done;

    // Reference model state
    logic [`CCU_VQ_DEPTH-1:0]      m_valid = '0;
    logic [`CCU_VQ_ADDR_WIDTH-1:0] m_addr [`CCU_VQ_DEPTH];
    logic [`CCU_VQ_LINE_WIDTH-1:0] m_data [`CCU_VQ_DEPTH];
    logic                          m_busy = 1'b0;
    vq_idx_t                       m_idx = '0;
    logic [`CCU_VQ_ADDR_WIDTH-1:0] exp_wb_addr [$];
    logic [`CCU_VQ_LINE_WIDTH-1:0] exp_wb_data [$];
    logic [`CCU_VQ_ADDR_WIDTH-1:0] last_wb_addr = '0;

    logic  stall_mem;
    bit    checks_on = 1'b0;
    int    cycle_count = 0;
    int    timeout_limit = 0;
    step_t steps [$];

    ccu_vq_top dut (
        .clk           (clk),
        .i_rst         (i_rst),
        .i_vict_en     (i_vict_en),
        .i_vict_addr   (i_vict_addr),
        .i_vict_data   (i_vict_data),
        .o_full        (o_full),
        .i_lookup_addr (i_lookup_addr),
        .o_lookup_hit  (o_lookup_hit),
        .o_lookup_data (o_lookup_data),
        .o_wb_req      (o_wb_req),
        .o_wb_addr     (o_wb_addr),
        .o_wb_data     (o_wb_data),
        .i_wb_done     (i_wb_done)
    );

    always #4 clk = ~clk;

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        assert (got === exp) else begin
            fail_run($sformatf("error: %s is 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    function automatic logic model_hit(input logic [`CCU_VQ_ADDR_WIDTH-1:0] addr);
        logic hit;
        hit = 1'b0;
        for (int i = 0; i < `CCU_VQ_DEPTH; i++) begin
            if (m_valid[i] && m_addr[i] == addr) hit = 1'b1;
        end
        return hit;
    endfunction

    function automatic logic [`CCU_VQ_LINE_WIDTH-1:0] model_data(
            input logic [`CCU_VQ_ADDR_WIDTH-1:0] addr);
        logic [`CCU_VQ_LINE_WIDTH-1:0] data;
        data = '0;
        for (int i = 0; i < `CCU_VQ_DEPTH; i++) begin
            if (m_valid[i] && m_addr[i] == addr) data = m_data[i];
        end
        return data;
    endfunction

    // Lowest free slot takes a victim, lowest valid slot drains, all from pre-edge state
    always @(posedge clk) begin : ref_model
        logic [`CCU_VQ_DEPTH-1:0] pre_valid;
        vq_idx_t                  free_idx;
        vq_idx_t                  pick_idx;
        bit                       has_free;
        bit                       has_valid;
        if (i_rst) begin
            m_valid = '0;
            m_busy  = 1'b0;
            exp_wb_addr.delete();
            exp_wb_data.delete();
        end else begin
            pre_valid = m_valid;
            free_idx  = '0;
            pick_idx  = '0;
            has_free  = 1'b0;
            has_valid = 1'b0;
            for (int i = `CCU_VQ_DEPTH - 1; i >= 0; i--) begin
                if (!pre_valid[i]) begin
                    free_idx = vq_idx_t'(i);
                    has_free = 1'b1;
                end else begin
                    pick_idx  = vq_idx_t'(i);
                    has_valid = 1'b1;
                end
            end
            if (m_busy) begin
                if (i_wb_done) begin
                    m_valid[m_idx] = 1'b0;
                    m_busy         = 1'b0;
                    last_wb_addr   = m_addr[m_idx];
                    void'(exp_wb_addr.pop_front());
                    void'(exp_wb_data.pop_front());
                end
            end else if (has_valid) begin
                m_busy = 1'b1;
                m_idx  = pick_idx;
                exp_wb_addr.push_back(m_addr[pick_idx]);
                exp_wb_data.push_back(m_data[pick_idx]);
            end
            if (i_vict_en && has_free) begin
                m_valid[free_idx] = 1'b1;
                m_addr[free_idx]  = i_vict_addr;
                m_data[free_idx]  = i_vict_data;
            end
        end
    end

    // Outputs are compared mid-cycle, well clear of the edges
    always @(negedge clk) begin
        if (checks_on) begin
            check_value("o_wb_req", 64'(o_wb_req), 64'(m_busy));
            check_value("o_full", 64'(o_full), 64'(&m_valid));
            if (m_busy) begin
                check_value("o_wb_addr", 64'(o_wb_addr), 64'(exp_wb_addr[0]));
                check_value("o_wb_data", o_wb_data, exp_wb_data[0]);
            end
            check_value("o_lookup_hit", 64'(o_lookup_hit), 64'(model_hit(i_lookup_addr)));
            check_value("o_lookup_data", o_lookup_data, model_data(i_lookup_addr));
        end
    end

    // Memory model that acknowledges a held request after a random wait unless stalled
    initial begin : mem_responder
        int unsigned delay;
        i_wb_done = 1'b0;
        forever begin
            @(posedge clk);
            #2;
            if (o_wb_req && !stall_mem) begin
                delay = $urandom % 6;
                repeat (delay) @(posedge clk);
                @(posedge clk);
                #1 i_wb_done = 1'b1;
                @(posedge clk);
                #1 i_wb_done = 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (timeout_limit > 0 && cycle_count > timeout_limit) begin
            fail_run("timeout: the test table did not finish within the cycle limit");
        end
    end

    task automatic add_step(input int op, input logic [`CCU_VQ_ADDR_WIDTH-1:0] addr,
                            input logic [`CCU_VQ_LINE_WIDTH-1:0] data, input bit chk,
                            input bit exp_bit, input logic [`CCU_VQ_LINE_WIDTH-1:0] exp_data);
        step_t s;
        s.op       = op;
        s.addr     = addr;
        s.data     = data;
        s.chk      = chk;
        s.exp_bit  = exp_bit;
        s.exp_data = exp_data;
        steps.push_back(s);
    endtask

    task automatic add_victim(input logic [`CCU_VQ_ADDR_WIDTH-1:0] addr,
                              input logic [`CCU_VQ_LINE_WIDTH-1:0] data);
        add_step(OP_VICT, addr, data, 1'b0, 1'b0, '0);
    endtask

    task automatic add_lookup(input logic [`CCU_VQ_ADDR_WIDTH-1:0] addr, input bit hit,
                              input logic [`CCU_VQ_LINE_WIDTH-1:0] data);
        add_step(OP_LOOK, addr, '0, 1'b1, hit, data);
    endtask

    task automatic add_op(input int op);
        add_step(op, '0, '0, 1'b0, 1'b0, '0);
    endtask

    task automatic build_table();
        // Single victims with lookups, then a full drain
        add_victim(26'h0001000, 64'h1111_0000_0000_0001);
        add_lookup(26'h0001000, 1'b1, 64'h1111_0000_0000_0001);
        add_lookup(26'h0002000, 1'b0, 64'h0);
        add_victim(26'h0003000, 64'h3333_0000_0000_0003);
        add_victim(26'h0004000, 64'h4444_0000_0000_0004);
        add_lookup(26'h0004000, 1'b1, 64'h4444_0000_0000_0004);
        add_op(OP_DRAIN);
        add_lookup(26'h0001000, 1'b0, 64'h0);
        add_lookup(26'h0004000, 1'b0, 64'h0);
        // Memory stalled, queue fills and the fifth victim is dropped
        add_op(OP_STALL_ON);
        add_victim(26'h0100000, 64'haaaa_0000_0000_00a0);
        add_victim(26'h0200000, 64'hbbbb_0000_0000_00b0);
        add_victim(26'h0300000, 64'hcccc_0000_0000_00c0);
        add_victim(26'h0400000, 64'hdddd_0000_0000_00d0);
        add_step(OP_FULL, '0, '0, 1'b1, 1'b1, '0);
        add_victim(26'h0500000, 64'heeee_0000_0000_00e0);
        add_lookup(26'h0500000, 1'b0, 64'h0);
        add_lookup(26'h0100000, 1'b1, 64'haaaa_0000_0000_00a0);
        add_lookup(26'h0200000, 1'b1, 64'hbbbb_0000_0000_00b0);
        add_lookup(26'h0300000, 1'b1, 64'hcccc_0000_0000_00c0);
        add_lookup(26'h0400000, 1'b1, 64'hdddd_0000_0000_00d0);
        // Release memory, slip a victim into a freed slot while draining
        add_op(OP_STALL_OFF);
        repeat (10) add_op(OP_IDLE);
        add_victim(26'h0600000, 64'hffff_0000_0000_00f0);
        add_lookup(26'h0600000, 1'b1, 64'hffff_0000_0000_00f0);
        add_op(OP_DRAIN);
        add_lookup(26'h0100000, 1'b0, 64'h0);
        add_lookup(26'h0600000, 1'b0, 64'h0);
        add_step(OP_FULL, '0, '0, 1'b1, 1'b0, '0);
    endtask

    // Lookups follow the last written-back line so its miss is checked each cycle
    task automatic wait_drained();
        while (m_busy || m_valid != '0 || exp_wb_addr.size() != 0) begin
            @(posedge clk);
            #1;
            i_lookup_addr = last_wb_addr;
        end
    endtask

    task automatic apply_step(input step_t s);
        @(posedge clk);
        #1;
        i_vict_en = 1'b0;
        case (s.op)
            OP_VICT: begin
                i_vict_en   = 1'b1;
                i_vict_addr = s.addr;
                i_vict_data = s.data;
            end
            OP_LOOK:      i_lookup_addr = s.addr;
            OP_STALL_ON:  stall_mem = 1'b1;
            OP_STALL_OFF: stall_mem = 1'b0;
            OP_DRAIN:     wait_drained();
            default:      ;
        endcase
        if (s.chk) begin
            @(negedge clk);
            if (s.op == OP_FULL) begin
                check_value("o_full", 64'(o_full), 64'(s.exp_bit));
            end else begin
                check_value("o_lookup_hit", 64'(o_lookup_hit), 64'(s.exp_bit));
                check_value("o_lookup_data", o_lookup_data, s.exp_data);
            end
        end
    endtask

    initial begin : main
        i_rst         = 1'b1;
        i_vict_en     = 1'b0;
        i_vict_addr   = '0;
        i_vict_data   = '0;
        i_lookup_addr = '0;
        stall_mem     = 1'b0;
        void'($urandom(59842));
        build_table();
        timeout_limit = 40 * steps.size() + 100;
        repeat (2) @(posedge clk);
        #1 i_rst = 1'b0;
        @(negedge clk);
        check_value("o_wb_req", 64'(o_wb_req), 64'h0);
        check_value("o_full", 64'(o_full), 64'h0);
        check_value("o_lookup_hit", 64'(o_lookup_hit), 64'h0);
        checks_on = 1'b1;
        foreach (steps[n]) begin
            apply_step(steps[n]);
        end
        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+hw
hw/ccu_vq_pkg.sv
hw/ccu_vq_entry.sv
hw/ccu_vq_alloc.sv
hw/ccu_vq_drain.sv
hw/ccu_vq_lookup.sv
hw/ccu_vq_top.sv
sim/ccu_vq_tb.sv

/* Makefile */
VERILATOR  ?= verilator
VFLAGS     = --binary --timing -j 0
LINT_FLAGS = --lint-only --timing -Wall
TOP        = ccu_vq_tb
RTL_TOP    = ccu_vq_top
FILELIST   = vlog.f
OBJ_DIR    = obj_dir
LOG        = sim.log
PASS_TEXT  = Everything OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
